//--- design/spio_pkt_pkg.sv
// SpiNNaker packet format shared by the link source, FIFO, sink and testbench
package spio_pkt_pkg;

	//////////////////////////////////////////////////
	// Field widths
	//////////////////////////////////////////////////

	localparam int PKT_BITS     = 72; // Whole packet
	localparam int KEY_BITS     = 32; // Routing key
	localparam int PAYLOAD_BITS = 32; // Optional payload word

	// Header field codes
	localparam logic [1:0] PKT_TYPE_MC  = 2'b00; // Multicast
	localparam logic [1:0] PKT_EM_NONE  = 2'b00; // Normal routing, no emergency
	localparam logic [1:0] PKT_TS_NONE  = 2'b00; // Timestamp not used

	// Whole packet XOR must equal this (odd parity)
	localparam logic PARITY_GOOD = 1'b1;

	//////////////////////////////////////////////////
	// Packet layout, MSB first
	//////////////////////////////////////////////////

	typedef struct packed
	{
		logic [PAYLOAD_BITS-1:0] payload;      // Data word
		logic [KEY_BITS-1:0]     key;          // Routing key
		logic [1:0]              pkt_type;     // MC/P2P/NN/FR
		logic [1:0]              em_state;     // Emergency routing
		logic [1:0]              timestamp;    // Phase stamp
		logic                    with_payload; // Payload word present
		logic                    parity;       // Bit 0
	} pkt_t;

	// XOR over every bit of a packet
	function automatic logic pkt_xor(input pkt_t pkt);
		return ^pkt;
	endfunction

endpackage

//--- design/spio_pkt_source.sv
// Packet source building multicast packets with a rolling key while send is held
`timescale 1ns/1ns

module spio_pkt_source
	import spio_pkt_pkg::*;
(
	input  logic usrclk2_i,
	input  logic reset_i,

	// Button request
	input  logic send_i,

	// Outgoing packet handshake
	output pkt_t pkt_o,
	output logic valid_o,
	input  logic ready_i
);

	// Key of the packet on offer, also number of packets already sent
	logic [KEY_BITS-1:0] key_q;

	// Packet before its parity bit is fixed
	pkt_t pkt_raw;

	//////////////////////////////////////////////////
	// Packet contents
	//////////////////////////////////////////////////

	always_comb
	begin
		pkt_raw              = '0;
		pkt_raw.payload      = ~key_q;      // Complement of the key
		pkt_raw.key          = key_q;
		pkt_raw.pkt_type     = PKT_TYPE_MC; // Multicast only
		pkt_raw.em_state     = PKT_EM_NONE;
		pkt_raw.timestamp    = PKT_TS_NONE;
		pkt_raw.with_payload = 1'b1;        // Always carries a payload
		pkt_raw.parity       = 1'b0;        // Filled in below
	end

	// Choose bit 0 so the whole packet has odd parity
	always_comb
	begin
		pkt_o        = pkt_raw;
		pkt_o.parity = PARITY_GOOD ^ pkt_xor(pkt_raw);
	end

	//////////////////////////////////////////////////
	// Handshake and key counter
	//////////////////////////////////////////////////

	// Offer changes only when nothing is pending or the pending one goes
	always_ff @(posedge usrclk2_i or posedge reset_i)
	begin
		if (reset_i)
		begin
			valid_o <= 1'b0;
			key_q   <= '0;
		end
		else if (!valid_o || ready_i)
		begin
			if (valid_o)
				key_q <= key_q + KEY_BITS'(1); // Accepted, next key

			// Back-to-back while the button stays down
			valid_o <= send_i;
		end
	end

endmodule

//--- design/spio_pkt_fifo.sv
// Packet FIFO on the transmit path absorbing link back-pressure
`timescale 1ns/1ns

module spio_pkt_fifo
	import spio_pkt_pkg::*;
#(
	parameter int FIFO_DEPTH = 4 // Entries, power of two
)
(
	input  logic usrclk2_i,
	input  logic reset_i,

	// Write side, from the source
	input  pkt_t in_data_i,
	input  logic in_valid_i,
	output logic in_ready_o,

	// Read side, toward the link
	output pkt_t out_data_o,
	output logic out_valid_o,
	input  logic out_ready_i
);

	localparam int PTR_BITS = $clog2(FIFO_DEPTH);

	// Occupancy at which writes are refused
	localparam logic [PTR_BITS:0] FULL_COUNT = (PTR_BITS+1)'(FIFO_DEPTH);

	logic [PKT_BITS-1:0] mem [FIFO_DEPTH]; // Packet storage

	logic [PTR_BITS-1:0] wr_ptr; // Next slot to fill
	logic [PTR_BITS-1:0] rd_ptr; // Head of queue
	logic [PTR_BITS:0]   count;  // Entries held

	logic push;
	logic pop;

	//////////////////////////////////////////////////
	// Handshakes
	//////////////////////////////////////////////////

	assign in_ready_o  = (count != FULL_COUNT); // Low only when full
	assign out_valid_o = (count != '0);
	assign push        = in_valid_i & in_ready_o;
	assign pop         = out_valid_o & out_ready_i;

	// Head entry straight from the storage registers
	assign out_data_o = pkt_t'(mem[rd_ptr]);

	//////////////////////////////////////////////////
	// Storage
	//////////////////////////////////////////////////

	always_ff @(posedge usrclk2_i)
	begin
		if (push)
			mem[wr_ptr] <= in_data_i;
	end

	//////////////////////////////////////////////////
	// Pointers and occupancy
	//////////////////////////////////////////////////

	always_ff @(posedge usrclk2_i or posedge reset_i)
	begin
		if (reset_i)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + PTR_BITS'(1); // Wraps at depth
			if (pop)
				rd_ptr <= rd_ptr + PTR_BITS'(1);

			case ({push, pop})
				2'b10:   count <= count + (PTR_BITS+1)'(1);
				2'b01:   count <= count - (PTR_BITS+1)'(1);
				default: count <= count; // Idle or simultaneous push/pop
			endcase
		end
	end

endmodule

//--- design/spio_pkt_sink.sv
// Packet sink checking parity, recording the last parity bit and stalling on error
`timescale 1ns/1ns

module spio_pkt_sink
	import spio_pkt_pkg::*;
(
	input  logic usrclk2_i,
	input  logic reset_i,

	// Incoming packet handshake
	input  pkt_t pkt_i,
	input  logic valid_i,
	output logic ready_o,

	input  logic error_clear_i, // Releases the stall

	// Status
	output logic parity_o,
	output logic error_o
);

	logic transfer;   // Packet accepted this cycle
	logic parity_bad; // Offered packet fails odd parity
	logic error_q;    // Sticky parity error
	logic parity_q;   // Bit 0 of the last accepted packet

	// Accept everything until an error is latched
	assign ready_o  = ~error_q;
	assign transfer = valid_i & ready_o;

	// Whole-packet reduction
	assign parity_bad = (pkt_xor(pkt_i) != PARITY_GOOD);

	//////////////////////////////////////////////////
	// Status registers
	//////////////////////////////////////////////////

	always_ff @(posedge usrclk2_i or posedge reset_i)
	begin
		if (reset_i)
		begin
			error_q  <= 1'b0;
			parity_q <= 1'b0;
		end
		else
		begin
			if (transfer)
				parity_q <= pkt_i.parity; // Even for a bad packet

			// A bad packet outranks a clear in the same cycle
			if (transfer && parity_bad)
				error_q <= 1'b1;
			else if (error_clear_i)
				error_q <= 1'b0;
		end
	end

	assign parity_o = parity_q;
	assign error_o  = error_q;

endmodule

//--- design/spio_link_leds.sv
// Link activity detector stretching packet transfers into a visible LED pulse
`timescale 1ns/1ns

module spio_link_leds
#(
	parameter int ACTIVITY_TIMEOUT = 64 // Cycles the LED stays lit
)
(
	input  logic usrclk2_i,
	input  logic reset_i,

	// Transmit port handshake
	input  logic tx_valid_i,
	input  logic tx_ready_i,

	// Receive port handshake
	input  logic rx_valid_i,
	input  logic rx_ready_i,

	output logic activity_o
);

	localparam int CNT_BITS = $clog2(ACTIVITY_TIMEOUT + 1);

	// Reload value after any transfer
	localparam logic [CNT_BITS-1:0] RELOAD = CNT_BITS'(ACTIVITY_TIMEOUT);

	logic                tx_xfer;
	logic                rx_xfer;
	logic [CNT_BITS-1:0] count; // Cycles of glow left

	//////////////////////////////////////////////////
	// Transfer detection
	//////////////////////////////////////////////////

	assign tx_xfer = tx_valid_i & tx_ready_i;
	assign rx_xfer = rx_valid_i & rx_ready_i;

	//////////////////////////////////////////////////
	// Timeout counter
	//////////////////////////////////////////////////

	always_ff @(posedge usrclk2_i or posedge reset_i)
	begin
		if (reset_i)
			count <= '0;
		else if (tx_xfer || rx_xfer)
			count <= RELOAD; // Restart the stretch
		else if (count != '0)
			count <= count - CNT_BITS'(1);
	end

	// Lit until the counter runs out
	assign activity_o = (count != '0);

endmodule

//--- design/spio_link_top.sv
// Peripheral link top level joining packet source, transmit FIFO, sink and status LEDs
`timescale 1ns/1ns

module spio_link_top
	import spio_pkt_pkg::*;
#(
	parameter int FIFO_DEPTH       = 4,  // Transmit buffer entries
	parameter int ACTIVITY_TIMEOUT = 64  // LED stretch in cycles
)
(
	input  logic usrclk2_i,
	input  logic reset_i,

	// Buttons
	input  logic send_i,
	input  logic error_clear_i,

	// Outgoing packets toward SpiNNaker
	output pkt_t pkt_tx_data_o,
	output logic pkt_tx_valid_o,
	input  logic pkt_tx_ready_i,

	// Incoming packets from SpiNNaker
	input  pkt_t pkt_rx_data_i,
	input  logic pkt_rx_valid_i,
	output logic pkt_rx_ready_o,

	// Status LEDs
	output logic led_activity_o,
	output logic led_parity_o,
	output logic led_error_o
);

	// Source to FIFO
	pkt_t src_data;
	logic src_valid;
	logic src_ready;

	//////////////////////////////////////////////////
	// Transmit path
	//////////////////////////////////////////////////

	spio_pkt_source u_source
	(
		.usrclk2_i (usrclk2_i),
		.reset_i   (reset_i),
		.send_i    (send_i),
		.pkt_o     (src_data),
		.valid_o   (src_valid),
		.ready_i   (src_ready)
	);

	spio_pkt_fifo
	#(
		.FIFO_DEPTH (FIFO_DEPTH)
	)
	u_fifo
	(
		.usrclk2_i   (usrclk2_i),
		.reset_i     (reset_i),
		.in_data_i   (src_data),
		.in_valid_i  (src_valid),
		.in_ready_o  (src_ready),
		.out_data_o  (pkt_tx_data_o),
		.out_valid_o (pkt_tx_valid_o),
		.out_ready_i (pkt_tx_ready_i)
	);

	//////////////////////////////////////////////////
	// Receive path
	//////////////////////////////////////////////////

	spio_pkt_sink u_sink
	(
		.usrclk2_i     (usrclk2_i),
		.reset_i       (reset_i),
		.pkt_i         (pkt_rx_data_i),
		.valid_i       (pkt_rx_valid_i),
		.ready_o       (pkt_rx_ready_o),
		.error_clear_i (error_clear_i),
		.parity_o      (led_parity_o), // Last received parity bit
		.error_o       (led_error_o)
	);

	//////////////////////////////////////////////////
	// Activity LED
	//////////////////////////////////////////////////

	spio_link_leds
	#(
		.ACTIVITY_TIMEOUT (ACTIVITY_TIMEOUT)
	)
	u_leds
	(
		.usrclk2_i  (usrclk2_i),
		.reset_i    (reset_i),
		.tx_valid_i (pkt_tx_valid_o),
		.tx_ready_i (pkt_tx_ready_i),
		.rx_valid_i (pkt_rx_valid_i),
		.rx_ready_i (pkt_rx_ready_o),
		.activity_o (led_activity_o)
	);

endmodule

//--- dv/spio_link_tb.sv
// Testbench driving random traffic through the peripheral link top level against a packet model
`timescale 1ns/1ns

module spio_link_tb
	import spio_pkt_pkg::*;
();

	localparam int CLK_PERIOD   = 100;
	localparam int RESET_CYCLES = 5;
	localparam int FIFO_DEPTH   = 4;
	localparam int ACT_TIMEOUT  = 8;  // Short stretch so it falls inside the run
	localparam int N_TX         = 200; // Random-ready transmit cycles
	localparam int DRAIN_CYCLES = 20;
	localparam int N_RX         = 100;
	localparam int ERR_CYCLES   = 20; // Upper bound of the error test
	localparam int IDLE_CYCLES  = ACT_TIMEOUT + 4;

	// Whole run plus generous margin
	localparam int TEST_CYCLES = RESET_CYCLES + 2 + N_TX + DRAIN_CYCLES + N_RX
		+ ERR_CYCLES + 3 * IDLE_CYCLES;
	localparam int WATCHDOG_CYCLES = 2 * TEST_CYCLES;

	logic usrclk2;
	logic reset;
	logic send_i;
	logic error_clear_i;
	pkt_t pkt_tx_data_o;
	logic pkt_tx_valid_o;
	logic pkt_tx_ready_i;
	pkt_t pkt_rx_data_i;
	logic pkt_rx_valid_i;
	logic pkt_rx_ready_o;
	logic led_activity_o;
	logic led_parity_o;
	logic led_error_o;

	// Model state
	logic [31:0]         seed = 32'h275a;
	logic [KEY_BITS-1:0] exp_key;    // Key of the next packet out
	logic                exp_parity; // Parity LED
	logic                exp_error;  // Error latch
	int                  cycle_cnt;  // Rising edges since reset release
	int                  last_xfer;  // Cycle stamp of the last transfer
	logic                seen_xfer;

	spio_link_top
	#(
		.FIFO_DEPTH       (FIFO_DEPTH),
		.ACTIVITY_TIMEOUT (ACT_TIMEOUT)
	)
	uut
	(
		.usrclk2_i      (usrclk2),
		.reset_i        (reset),
		.send_i         (send_i),
		.error_clear_i  (error_clear_i),
		.pkt_tx_data_o  (pkt_tx_data_o),
		.pkt_tx_valid_o (pkt_tx_valid_o),
		.pkt_tx_ready_i (pkt_tx_ready_i),
		.pkt_rx_data_i  (pkt_rx_data_i),
		.pkt_rx_valid_i (pkt_rx_valid_i),
		.pkt_rx_ready_o (pkt_rx_ready_o),
		.led_activity_o (led_activity_o),
		.led_parity_o   (led_parity_o),
		.led_error_o    (led_error_o)
	);

	initial
	begin
		usrclk2 = 1'b0;
		forever #(CLK_PERIOD / 2) usrclk2 = ~usrclk2;
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	function automatic logic [31:0] next_random();
		seed = seed * 32'd1664525 + 32'd1013904223; // Numerical Recipes LCG
		return seed;
	endfunction

	task automatic check(input string name, input logic [PKT_BITS-1:0] got,
		input logic [PKT_BITS-1:0] exp);
		if (got !== exp)
		begin
			$display("CHECK FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
			$display("** FAIL **");
			$fatal(1, "value mismatch on %s", name);
		end
	endtask

	// Multicast packet the source should emit for a key
	function automatic pkt_t expected_tx_pkt(input logic [KEY_BITS-1:0] key);
		pkt_t p;
		p              = '0;
		p.payload      = ~key;
		p.key          = key;
		p.pkt_type     = PKT_TYPE_MC;
		p.with_payload = 1'b1;
		p.parity       = ~(^p); // Total XOR becomes 1
		return p;
	endfunction

	function automatic pkt_t random_rx_pkt(input logic good);
		logic [PKT_BITS-1:0] bits;
		logic [31:0]         low;
		bits[71:40] = next_random();
		bits[39:8]  = next_random();
		low         = next_random();
		bits[7:0]   = low[15:8];
		bits[0]     = 1'b0;
		bits[0]     = ~(^bits); // Odd parity
		if (!good)
			bits[0] = ~bits[0]; // Break it
		return pkt_t'(bits);
	endfunction

	// One clock from falling edge to falling edge with the activity LED checked
	task automatic tick();
		logic xfer;
		xfer = (pkt_tx_valid_o && pkt_tx_ready_i) || (pkt_rx_valid_i && pkt_rx_ready_o);
		@(posedge usrclk2);
		@(negedge usrclk2);
		cycle_cnt++;
		if (xfer)
		begin
			seen_xfer = 1'b1;
			last_xfer = cycle_cnt;
		end
		check("led_activity_o", led_activity_o,
			seen_xfer && ((cycle_cnt - last_xfer) < ACT_TIMEOUT));
	endtask

	// Transmit cycle with content and stall checks
	task automatic tx_cycle(input logic ready);
		pkt_t held;
		logic stalled;
		pkt_tx_ready_i = ready;
		stalled        = pkt_tx_valid_o && !ready;
		held           = pkt_tx_data_o;
		if (pkt_tx_valid_o && ready)
		begin
			check("pkt_tx_data_o", pkt_tx_data_o, expected_tx_pkt(exp_key));
			exp_key++; // Next key in sequence
		end
		tick();
		if (stalled)
		begin
			check("pkt_tx_valid_o", pkt_tx_valid_o, 1'b1); // Held under back-pressure
			check("pkt_tx_data_o", pkt_tx_data_o, held);
		end
	endtask

	// Receive cycle with the sink model stepped alongside
	task automatic rx_cycle(input logic valid, input pkt_t pkt);
		logic accepted;
		pkt_rx_valid_i = valid;
		pkt_rx_data_i  = pkt;
		check("pkt_rx_ready_o", pkt_rx_ready_o, !exp_error);
		accepted = valid && !exp_error;
		if (accepted)
			exp_parity = pkt.parity;
		if (accepted && ((^pkt) != 1'b1))
			exp_error = 1'b1; // Even parity latches
		else if (error_clear_i)
			exp_error = 1'b0;
		tick();
		check("led_parity_o", led_parity_o, exp_parity);
		check("led_error_o", led_error_o, exp_error);
		check("pkt_rx_ready_o", pkt_rx_ready_o, !exp_error);
	endtask

	//////////////////////////////////////////////////
	// Watchdog
	//////////////////////////////////////////////////

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired: the test did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("** FAIL **");
		$fatal(1, "timeout");
	end

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial
	begin
		logic [31:0] r;
		int          n;
		reset          = 1'b1;
		send_i         = 1'b0;
		error_clear_i  = 1'b0;
		pkt_tx_ready_i = 1'b0;
		pkt_rx_data_i  = '0;
		pkt_rx_valid_i = 1'b0;
		exp_key        = '0;
		exp_parity     = 1'b0;
		exp_error      = 1'b0;
		cycle_cnt      = 0;
		last_xfer      = 0;
		seen_xfer      = 1'b0;

		repeat (RESET_CYCLES) @(posedge usrclk2);
		@(negedge usrclk2);
		reset = 1'b0;

		// Reset state
		check("pkt_tx_valid_o", pkt_tx_valid_o, 1'b0);
		check("led_activity_o", led_activity_o, 1'b0);
		check("led_parity_o", led_parity_o, 1'b0);
		check("led_error_o", led_error_o, 1'b0);
		check("pkt_rx_ready_o", pkt_rx_ready_o, 1'b1);

		// First valid two cycles after send from idle
		send_i = 1'b1;
		tick();
		check("pkt_tx_valid_o", pkt_tx_valid_o, 1'b0);
		tick();
		check("pkt_tx_valid_o", pkt_tx_valid_o, 1'b1);

		// Button held with random link ready
		for (int i = 0; i < N_TX; i++)
		begin
			r = next_random();
			tx_cycle(r[16]);
		end

		// Release and drain
		send_i = 1'b0;
		n      = 0;
		while (pkt_tx_valid_o && n < DRAIN_CYCLES)
		begin
			tx_cycle(1'b1);
			n++;
		end
		check("pkt_tx_valid_o", pkt_tx_valid_o, 1'b0);
		pkt_tx_ready_i = 1'b0;
		repeat (IDLE_CYCLES) tick(); // LED must fall here

		// Good packets with random valid
		for (int i = 0; i < N_RX; i++)
		begin
			r = next_random();
			rx_cycle(r[12], random_rx_pkt(1'b1));
		end

		// Bad parity then stall then clear
		rx_cycle(1'b1, random_rx_pkt(1'b0));
		check("led_error_o", led_error_o, 1'b1);
		r = next_random();
		n = 3 + (r[18:16] % 8);
		for (int i = 0; i < n; i++)
		begin
			r = next_random();
			rx_cycle(r[9], random_rx_pkt(r[10]));
		end
		error_clear_i = 1'b1;
		rx_cycle(1'b0, '0);
		error_clear_i = 1'b0;
		check("led_error_o", led_error_o, 1'b0);
		check("pkt_rx_ready_o", pkt_rx_ready_o, 1'b1);
		repeat (4) rx_cycle(1'b1, random_rx_pkt(1'b1)); // Traffic flows again

		// Final stretch runs out
		pkt_rx_valid_i = 1'b0;
		repeat (IDLE_CYCLES) tick();
		check("led_activity_o", led_activity_o, 1'b0);

		$display("** PASS **");
		$finish;
	end

endmodule

//--- spio_link.f
design/spio_pkt_pkg.sv
design/spio_pkt_source.sv
design/spio_pkt_fifo.sv
design/spio_pkt_sink.sv
design/spio_link_leds.sv
design/spio_link_top.sv
dv/spio_link_tb.sv
